/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := fetch_front_tb
FILELIST  := fetch_front.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST))) src/fetch_defs.svh

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# fails unless the pass line shows up in the output
run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* fetch_front.f */
+incdir+src
src/fetch_pkg.sv
src/mem_arbiter.sv
src/icache.sv
src/fetch_unit.sv
src/fetch_front.sv
verif/mem_model.sv
verif/fetch_front_checker.sv
verif/fetch_front_tb.sv

/* src/fetch_defs.svh */
// fetch front end constants
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

`default_nettype none

////////////////////////////////////////
// datapath widths
////////////////////////////////////////

// address and instruction width
`define XLEN 32
// one memory word, also one cache line
`define LINE_BITS 64
// memory transaction tag, zero means no transaction
`define MEM_TAG_BITS 4

////////////////////////////////////////
// icache geometry
////////////////////////////////////////

`define ICACHE_LINES 32
`define ICACHE_INDEX_BITS 5
// byte offset inside a 64-bit line
`define ICACHE_OFFSET_BITS 3
// address bits above index and offset
`define ICACHE_TAG_BITS 24

////////////////////////////////////////
// memory bus commands
////////////////////////////////////////

`define BUS_CMD_BITS 2
`define BUS_NONE 2'b00
`define BUS_LOAD 2'b01
`define BUS_STORE 2'b10

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`default_nettype wire

`endif

/* src/fetch_front.sv */
// fetch front end top level
`timescale 1ns/10ps
`include "fetch_defs.svh"

`default_nettype none

module fetch_front
    import fetch_pkg::*;
(
    input  logic          clock,
    input  logic          reset,

    // decode side
    input  logic          stall,
    input  logic          take_branch,
    input  addr_t         branch_target,
    output fetch_packet_t fetch_packet,

    // external data client
    input  mem_req_t      data_req,
    output mem_rsp_t      data_rsp,

    // shared memory bus
    output mem_req_t      mem_req,
    input  mem_rsp_t      mem_rsp
);

    ////////////////////////////////////////
    // internal wires
    ////////////////////////////////////////

    // fetch to icache
    addr_t    fetch_addr;
    line_t    line;
    logic     hit;

    // icache to arbiter
    mem_req_t refill_req;
    mem_rsp_t refill_rsp;

    fetch_unit u_fetch (
        .clock         (clock),
        .reset         (reset),
        .stall         (stall),
        .take_branch   (take_branch),
        .branch_target (branch_target),
        .line          (line),
        .hit           (hit),
        .fetch_addr    (fetch_addr),
        .fetch_packet  (fetch_packet)
    );

    icache u_icache (
        .clock      (clock),
        .reset      (reset),
        .fetch_addr (fetch_addr),
        .line       (line),
        .hit        (hit),
        .refill_req (refill_req),
        .refill_rsp (refill_rsp)
    );

    // data client has priority over refills
    mem_arbiter u_arbiter (
        .data_req   (data_req),
        .data_rsp   (data_rsp),
        .refill_req (refill_req),
        .refill_rsp (refill_rsp),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp)
    );

endmodule

`default_nettype wire

/* src/fetch_pkg.sv */
// fetch front end types
`include "fetch_defs.svh"

`default_nettype none

package fetch_pkg;

    ////////////////////////////////////////
    // plain vector types
    ////////////////////////////////////////

    // byte address
    typedef logic [`XLEN-1:0] addr_t;
    // one instruction word
    typedef logic [`XLEN-1:0] inst_t;
    // memory word, same width as a cache line
    typedef logic [`LINE_BITS-1:0] line_t;
    // transaction tag on the memory bus
    typedef logic [`MEM_TAG_BITS-1:0] mem_tag_t;
    // BUS_NONE / BUS_LOAD / BUS_STORE
    typedef logic [`BUS_CMD_BITS-1:0] bus_cmd_t;

    ////////////////////////////////////////
    // bus structs
    ////////////////////////////////////////

    // command side, held until response is nonzero
    typedef struct packed {
        bus_cmd_t cmd;
        addr_t    addr;
        line_t    data;
    } mem_req_t;

    // response tag same cycle, data and data tag later
    typedef struct packed {
        mem_tag_t response;
        line_t    data;
        mem_tag_t tag;
    } mem_rsp_t;

    // fetch output toward decode
    typedef struct packed {
        logic  valid;
        addr_t pc;
        addr_t npc;
        inst_t inst;
    } fetch_packet_t;

    // icache miss handling
    typedef enum logic [1:0] {
        ICACHE_IDLE,
        ICACHE_REQUEST,
        ICACHE_WAIT_DATA
    } icache_state_e;

endpackage

`default_nettype wire

/* src/fetch_unit.sv */
// instruction fetch unit
`timescale 1ns/10ps
`include "fetch_defs.svh"

`default_nettype none

module fetch_unit
    import fetch_pkg::*;
(
    input  logic          clock,
    input  logic          reset,

    // back-pressure from decode
    input  logic          stall,

    // redirect
    input  logic          take_branch,
    input  addr_t         branch_target,

    // icache lookup
    input  line_t         line,
    input  logic          hit,
    output addr_t         fetch_addr,

    // registered packet to decode
    output fetch_packet_t fetch_packet
);

    addr_t pc;
    addr_t seq_pc;
    inst_t sel_inst;

    ////////////////////////////////////////
    // lookup and word select
    ////////////////////////////////////////

    assign fetch_addr = pc;
    assign seq_pc     = pc + addr_t'(4);

    // bit 2 picks the upper word of the 64-bit line
    assign sel_inst = pc[2] ? line[`LINE_BITS-1:`XLEN] : line[`XLEN-1:0];

    ////////////////////////////////////////
    // pc and packet register
    ////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pc           <= `RESET_PC;
            fetch_packet <= '0;
        end else if (!stall) begin
            if (take_branch) begin
                // redirect wins over sequential
                pc                 <= branch_target;
                fetch_packet.valid <= 1'b0;
            end else if (hit) begin
                pc                 <= seq_pc;
                fetch_packet.valid <= 1'b1;
                fetch_packet.pc    <= pc;
                fetch_packet.npc   <= seq_pc;
                fetch_packet.inst  <= sel_inst;
            end else begin
                // miss, bubble until the line fills
                fetch_packet.valid <= 1'b0;
            end
        end
        // stall holds both pc and packet
    end

endmodule

`default_nettype wire

/* src/icache.sv */
// direct-mapped instruction cache
`timescale 1ns/10ps
`include "fetch_defs.svh"

`default_nettype none

module icache
    import fetch_pkg::*;
(
    input  logic     clock,
    input  logic     reset,

    // lookup from fetch
    input  addr_t    fetch_addr,
    output line_t    line,
    output logic     hit,

    // refill port toward the arbiter
    output mem_req_t refill_req,
    input  mem_rsp_t refill_rsp
);

    localparam int LINE_ADDR_BITS = `XLEN - `ICACHE_OFFSET_BITS;

    ////////////////////////////////////////
    // storage
    ////////////////////////////////////////

    line_t                       data_mem [`ICACHE_LINES];
    logic [`ICACHE_TAG_BITS-1:0] tag_mem  [`ICACHE_LINES];
    logic [`ICACHE_LINES-1:0]    valid_bits;

    // lookup fields
    logic [`ICACHE_INDEX_BITS-1:0] rd_index;
    logic [`ICACHE_TAG_BITS-1:0]   rd_tag;

    // miss tracking
    icache_state_e               state;
    icache_state_e               next_state;
    logic [LINE_ADDR_BITS-1:0]   miss_line;
    mem_tag_t                    pend_tag;
    logic                        fill;
    logic [`ICACHE_INDEX_BITS-1:0] miss_index;
    logic [`ICACHE_TAG_BITS-1:0]   miss_tag;

    ////////////////////////////////////////
    // hit path, zero cycles
    ////////////////////////////////////////

    assign rd_index = fetch_addr[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
    assign rd_tag   = fetch_addr[`XLEN-1 -: `ICACHE_TAG_BITS];

    assign line = data_mem[rd_index];
    assign hit  = valid_bits[rd_index] && (tag_mem[rd_index] == rd_tag);

    // line being refilled
    assign miss_index = miss_line[`ICACHE_INDEX_BITS-1:0];
    assign miss_tag   = miss_line[LINE_ADDR_BITS-1 -: `ICACHE_TAG_BITS];

    // data returns with the tag memory handed out
    assign fill = (state == ICACHE_WAIT_DATA) && (refill_rsp.tag == pend_tag);

    ////////////////////////////////////////
    // miss FSM
    ////////////////////////////////////////

    always_comb begin
        next_state = state;
        refill_req = '0;
        case (state)
            ICACHE_IDLE: begin
                if (!hit) begin
                    next_state = ICACHE_REQUEST;
                end
            end
            ICACHE_REQUEST: begin
                // hold the load until memory hands out a tag
                refill_req.cmd  = `BUS_LOAD;
                refill_req.addr = {miss_line, {`ICACHE_OFFSET_BITS{1'b0}}};
                if (refill_rsp.response != '0) begin
                    next_state = ICACHE_WAIT_DATA;
                end
            end
            ICACHE_WAIT_DATA: begin
                if (fill) begin
                    next_state = ICACHE_IDLE;
                end
            end
            default: begin
                next_state = ICACHE_IDLE;
            end
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state      <= ICACHE_IDLE;
            pend_tag   <= '0;
            valid_bits <= '0;
        end else begin
            state <= next_state;
            // remember the accepted tag for the data match
            if (state == ICACHE_REQUEST && refill_rsp.response != '0) begin
                pend_tag <= refill_rsp.response;
            end
            if (fill) begin
                valid_bits[miss_index] <= 1'b1;
                pend_tag               <= '0;
            end
        end
    end

    ////////////////////////////////////////
    // line write and miss address
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        // latch line address on the miss, stable through request
        if (state == ICACHE_IDLE && !hit) begin
            miss_line <= fetch_addr[`XLEN-1:`ICACHE_OFFSET_BITS];
        end
        if (fill) begin
            data_mem[miss_index] <= refill_rsp.data;
            tag_mem[miss_index]  <= miss_tag;
        end
    end

endmodule

`default_nettype wire

/* src/mem_arbiter.sv */
// memory port arbiter
`timescale 1ns/10ps
`include "fetch_defs.svh"

`default_nettype none

module mem_arbiter
    import fetch_pkg::*;
(
    // data client side
    input  mem_req_t data_req,
    output mem_rsp_t data_rsp,

    // icache refill side
    input  mem_req_t refill_req,
    output mem_rsp_t refill_rsp,

    // shared memory bus
    output mem_req_t mem_req,
    input  mem_rsp_t mem_rsp
);

    // data client owns the bus whenever it presents a command
    logic data_sel;

    assign data_sel = (data_req.cmd != `BUS_NONE);

    ////////////////////////////////////////
    // command mux
    ////////////////////////////////////////

    // purely combinational, no ownership state
    // refill load goes out only when data side is quiet
    always_comb begin
        if (data_sel) begin
            mem_req = data_req;
        end else begin
            mem_req = refill_req;
        end
    end

    ////////////////////////////////////////
    // response steering
    ////////////////////////////////////////

    // data and data tag broadcast to both sides
    // each requester matches against its own recorded tag
    always_comb begin
        data_rsp   = mem_rsp;
        refill_rsp = mem_rsp;
        // accept tag only to the side that drove the bus
        if (data_sel) begin
            // zero tag here stalls the refill FSM in request
            refill_rsp.response = '0;
        end else begin
            data_rsp.response = '0;
        end
    end

endmodule

`default_nettype wire

/* verif/fetch_front_checker.sv */
// fetch front protocol checker
`timescale 1ns/10ps
`include "fetch_defs.svh"

`default_nettype none

module fetch_front_checker
    import fetch_pkg::*;
(
    input logic          clock,
    input logic          reset,
    input mem_req_t      data_req,
    input mem_req_t      refill_req,
    input mem_rsp_t      refill_rsp,
    input logic          hit,
    input icache_state_e state
);

    // per-assertion failure counts
    int unsigned held_fails = 0;
    int unsigned steer_fails = 0;
    int unsigned idle_fails = 0;
    int unsigned fail_count;

    assign fail_count = held_fails + steer_fails + idle_fails;

    ////////////////////////////////////////
    // bus protocol
    ////////////////////////////////////////

    // refill load parked until memory takes it
    refill_held: assert property (@(posedge clock) disable iff (reset)
        (refill_req.cmd == `BUS_LOAD && refill_rsp.response == '0)
        |=> (refill_req.cmd == `BUS_LOAD && refill_req.addr == $past(refill_req.addr)))
    else begin
        $error("refill load dropped or moved before acceptance");
        held_fails++;
    end

    // data client owns the accept tag
    refill_blocked: assert property (@(posedge clock) disable iff (reset)
        (data_req.cmd != `BUS_NONE) |-> (refill_rsp.response == '0))
    else begin
        $error("refill side saw an accept tag during a data command");
        steer_fails++;
    end

    ////////////////////////////////////////
    // cache FSM
    ////////////////////////////////////////

    // no miss, no refill
    idle_on_hit: assert property (@(posedge clock) disable iff (reset)
        (state == ICACHE_IDLE && hit) |=> (state == ICACHE_IDLE))
    else begin
        $error("icache left idle on a hit");
        idle_fails++;
    end

endmodule

bind fetch_front fetch_front_checker u_checker (
    .clock      (clock),
    .reset      (reset),
    .data_req   (data_req),
    .refill_req (refill_req),
    .refill_rsp (refill_rsp),
    .hit        (hit),
    .state      (u_icache.state)
);

`default_nettype wire

/* verif/fetch_front_tb.sv */
// fetch front testbench
`timescale 1ns/10ps
`include "fetch_defs.svh"

`default_nettype none

module fetch_front_tb
    import fetch_pkg::*;
();

    localparam int    WAIT_LIMIT   = 200;
    localparam addr_t CONTENT_MASK = 32'h5A5A_0000;

    logic          clock;
    logic          reset;
    logic          stall;
    logic          take_branch;
    addr_t         branch_target;
    mem_req_t      data_req;
    mem_rsp_t      data_rsp;
    mem_req_t      mem_req;
    mem_rsp_t      mem_rsp;
    fetch_packet_t fetch_packet;

    int          mismatches;
    int          timeouts;
    int unsigned assert_fails;
    integer      seed;
    addr_t       next_pc;
    // shadow of the one store the data client makes
    logic        store_valid;
    addr_t       store_addr;
    line_t       store_data;

    fetch_front DUT (
        .clock         (clock),
        .reset         (reset),
        .stall         (stall),
        .take_branch   (take_branch),
        .branch_target (branch_target),
        .fetch_packet  (fetch_packet),
        .data_req      (data_req),
        .data_rsp      (data_rsp),
        .mem_req       (mem_req),
        .mem_rsp       (mem_rsp)
    );

    mem_model u_mem (
        .clock   (clock),
        .reset   (reset),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    ////////////////////////////////////////
    // expected content
    ////////////////////////////////////////

    function automatic inst_t expected_word(addr_t a);
        if (store_valid && a[31:3] == store_addr[31:3]) begin
            return a[2] ? store_data[63:32] : store_data[31:0];
        end
        return a ^ CONTENT_MASK;
    endfunction

    function automatic line_t expected_line(addr_t base);
        return {expected_word(base + 32'd4), expected_word(base)};
    endfunction

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got != exp) begin
            $display("mismatch %s: expected %h, got %h", name, exp, got);
            mismatches++;
        end
    endtask

    ////////////////////////////////////////
    // driver and monitor tasks
    ////////////////////////////////////////

    // next valid packet, sampled on the falling edge
    task automatic expect_packet(input addr_t pc);
        int count;
        count = 0;
        @(negedge clock);
        while (!fetch_packet.valid && count < WAIT_LIMIT) begin
            @(negedge clock);
            count++;
        end
        if (!fetch_packet.valid) begin
            $display("timeout: no valid fetch packet for pc %h", pc);
            timeouts++;
        end else begin
            compare("fetch_packet.pc", 64'(fetch_packet.pc), 64'(pc));
            compare("fetch_packet.npc", 64'(fetch_packet.npc), 64'(pc + 32'd4));
            compare("fetch_packet.inst", 64'(fetch_packet.inst), 64'(expected_word(pc)));
        end
        next_pc = pc + 32'd4;
    endtask

    // one-cycle redirect pulse
    task automatic redirect_to(input addr_t target);
        @(negedge clock);
        take_branch   = 1'b1;
        branch_target = target;
        @(negedge clock);
        take_branch = 1'b0;
        next_pc     = target;
        // redirect cycle is a bubble
        compare("fetch_packet.valid", 64'(fetch_packet.valid), 64'(0));
    endtask

    // hold a data command until accepted, then release it
    task automatic data_access(input bus_cmd_t cmd, input addr_t addr, input line_t wdata,
                               output mem_tag_t tag);
        int count;
        count         = 0;
        tag           = '0;
        data_req.cmd  = cmd;
        data_req.addr = addr;
        data_req.data = wdata;
        #1;
        while (data_rsp.response == '0 && count < WAIT_LIMIT) begin
            @(negedge clock);
            #1;
            count++;
        end
        if (data_rsp.response == '0) begin
            $display("timeout: data client command was never accepted");
            timeouts++;
        end else begin
            tag = data_rsp.response;
            // data side must own the bus
            compare("mem_req.addr", 64'(mem_req.addr), 64'(addr));
        end
        @(negedge clock);
        data_req = '0;
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////

    task automatic reset_state();
        compare("fetch_packet.valid", 64'(fetch_packet.valid), 64'(0));
        compare("mem_req.cmd", 64'(mem_req.cmd), 64'(`BUS_NONE));
        expect_packet(`RESET_PC);
    endtask

    task automatic sequential_run();
        for (int i = 0; i < 16; i++) begin
            expect_packet(next_pc);
        end
    endtask

    task automatic stall_hold();
        addr_t held;
        held = next_pc;
        expect_packet(held);
        stall = 1'b1;
        repeat (5) begin
            @(negedge clock);
            compare("fetch_packet.valid", 64'(fetch_packet.valid), 64'(1));
            compare("fetch_packet.pc", 64'(fetch_packet.pc), 64'(held));
        end
        stall = 1'b0;
        // nothing skipped after release
        expect_packet(held + 32'd4);
    endtask

    task automatic branch_redirect();
        redirect_to(32'h0000_1234);
        repeat (4) begin
            expect_packet(next_pc);
        end
    endtask

    task automatic refill_priority();
        mem_tag_t tag;
        int       count;
        logic     seen;
        redirect_to(32'h0000_2000);
        count = 0;
        seen  = 1'b0;
        // catch the refill load for the new line
        while (!seen && count < WAIT_LIMIT) begin
            @(negedge clock);
            seen = (mem_req.cmd == `BUS_LOAD) && (mem_req.addr == 32'h0000_2000);
            count++;
        end
        if (!seen) begin
            $display("timeout: refill load for the redirect target never appeared");
            timeouts++;
        end
        data_access(`BUS_LOAD, 32'h0000_0A48, '0, tag);
        count = 0;
        seen  = 1'b0;
        while (!seen && count < WAIT_LIMIT) begin
            @(negedge clock);
            seen = (tag != '0) && (data_rsp.tag == tag);
            count++;
        end
        if (!seen) begin
            $display("timeout: load data never returned to the data client");
            timeouts++;
        end else begin
            compare("data_rsp.data", data_rsp.data, expected_line(32'h0000_0A48));
        end
        repeat (3) begin
            expect_packet(next_pc);
        end
    endtask

    task automatic shared_store();
        mem_tag_t tag;
        line_t    value;
        value[31:0]  = $random(seed);
        value[63:32] = $random(seed);
        @(negedge clock);
        data_access(`BUS_STORE, 32'h0000_3000, value, tag);
        store_valid = 1'b1;
        store_addr  = 32'h0000_3000;
        store_data  = value;
        // fetch the stored line as code
        redirect_to(32'h0000_3000);
        expect_packet(next_pc);
        expect_packet(next_pc);
    endtask

    initial begin
        mismatches    = 0;
        timeouts      = 0;
        seed          = 78;
        store_valid   = 1'b0;
        store_addr    = '0;
        store_data    = '0;
        next_pc       = `RESET_PC;
        reset         = 1'b1;
        stall         = 1'b0;
        take_branch   = 1'b0;
        branch_target = '0;
        data_req      = '0;
        repeat (4) @(negedge clock);
        reset = 1'b0;

        reset_state();
        sequential_run();
        stall_hold();
        branch_redirect();
        refill_priority();
        shared_store();

        assert_fails = DUT.u_checker.fail_count;
        $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 mismatches, timeouts, assert_fails);
        if (mismatches == 0 && timeouts == 0 && assert_fails == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/mem_model.sv */
// tagged memory model
`timescale 1ns/10ps
`include "fetch_defs.svh"

`default_nettype none

module mem_model
    import fetch_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  mem_req_t mem_req,
    output mem_rsp_t mem_rsp
);

    localparam int LATENCY = 3;

    // lines overwritten by stores, keyed by line address
    line_t    written [addr_t];
    mem_tag_t next_tag;
    mem_tag_t pipe_tag  [LATENCY];
    line_t    pipe_data [LATENCY];
    addr_t    line_addr;

    // untouched word at a reads a ^ 5A5A_0000
    function automatic line_t read_line(addr_t base);
        if (written.exists(base)) begin
            return written[base];
        end
        return {(base + 32'd4) ^ 32'h5A5A_0000, base ^ 32'h5A5A_0000};
    endfunction

    assign line_addr = {mem_req.addr[`XLEN-1:`ICACHE_OFFSET_BITS], {`ICACHE_OFFSET_BITS{1'b0}}};

    // every command taken at once, tag never zero
    assign mem_rsp.response = next_tag;
    assign mem_rsp.tag      = pipe_tag[LATENCY-1];
    assign mem_rsp.data     = pipe_data[LATENCY-1];

    always @(posedge clock or posedge reset) begin
        if (reset) begin
            next_tag <= mem_tag_t'(1);
            for (int i = 0; i < LATENCY; i++) begin
                pipe_tag[i]  <= '0;
                pipe_data[i] <= '0;
            end
        end else begin
            // return pipeline, tag zero is an empty slot
            for (int i = 1; i < LATENCY; i++) begin
                pipe_tag[i]  <= pipe_tag[i-1];
                pipe_data[i] <= pipe_data[i-1];
            end
            pipe_tag[0]  <= '0;
            pipe_data[0] <= '0;
            if (mem_req.cmd != `BUS_NONE) begin
                // wrap past zero
                next_tag <= (next_tag == '1) ? mem_tag_t'(1) : next_tag + mem_tag_t'(1);
            end
            if (mem_req.cmd == `BUS_LOAD) begin
                pipe_tag[0]  <= next_tag;
                pipe_data[0] <= read_line(line_addr);
            end
            // stores return nothing
            if (mem_req.cmd == `BUS_STORE) begin
                written[line_addr] = mem_req.data;
            end
        end
    end

endmodule

`default_nettype wire
